/* build.f */
hdl/cpu_pkg.sv
hdl/ctrl_if.sv
hdl/alu_unit.sv
hdl/reg_file.sv
hdl/pc_unit.sv
hdl/ctrl_fsm.sv
hdl/datapath.sv
hdl/cpu_top.sv
tests/tb_checker.sv
tests/tb_top.sv

/* hdl/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit import cpu_pkg::*; (
    input  word_t   op1,
    input  word_t   op2,
    input  alu_op_t alu_op,
    output word_t   result,
    output logic    overflow
);

    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;

    assign sum  = op1 + op2;
    assign diff = op1 - op2;

    // same-sign operands giving a result of the other sign
    assign add_ovf = (op1[31] == op2[31]) && (sum[31] != op1[31]);
    assign sub_ovf = (op1[31] != op2[31]) && (diff[31] != op1[31]);

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = sum;
            ALU_SUB:  result = diff;
            ALU_AND:  result = op1 & op2;
            ALU_OR:   result = op1 | op2;
            ALU_XOR:  result = op1 ^ op2;
            ALU_NOR:  result = ~(op1 | op2);
            ALU_SLT:  result = {31'b0, $signed(op1) < $signed(op2)};
            ALU_SLTU: result = {31'b0, op1 < op2};
            default:  result = '0;
        endcase
    end

    assign overflow = (alu_op == ALU_ADD) ? add_ovf :
                      (alu_op == ALU_SUB) ? sub_ovf : 1'b0;

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    localparam int ADDR_BITS = 32;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDI  = 6'b001000,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_SLTIU = 6'b001011,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    // r-type function field, bits 5:0
    typedef enum logic [5:0] {
        F_ADD  = 6'b100000,
        F_ADDU = 6'b100001,
        F_SUB  = 6'b100010,
        F_SUBU = 6'b100011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_NOR  = 6'b100111,
        F_SLT  = 6'b101010,
        F_SLTU = 6'b101011
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    typedef enum logic [3:0] {
        S_FETCH,
        S_DECODE,
        S_ALU_EXE,
        S_ALU_WR,
        S_MEM_ADDR,
        S_MEM_RD,
        S_MEM_WB,
        S_MEM_WR,
        S_BRANCH,
        S_JUMP
    } state_t;

    typedef enum logic {OP2_REG, OP2_IMM} op2_sel_t;
    typedef enum logic {WA_RD, WA_RT} wr_addr_sel_t;
    typedef enum logic {WD_ALU, WD_MEM} wr_data_sel_t;
    typedef enum logic {EXT_SIGN, EXT_ZERO} ext_mode_t;

    typedef enum logic [1:0] {
        NPC_SEQ,
        NPC_BRANCH,
        NPC_JUMP
    } npc_sel_t;

endpackage

/* hdl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter logic [ADDR_BITS-1:0] RESET_PC = '0,
    parameter int                   NUM_REGS = 32
) (
    input  logic  clk,
    input  logic  rst,
    output word_t imem_addr,
    input  word_t imem_data,
    output word_t dm_addr,
    output word_t dm_wdata,
    input  word_t dm_rdata,
    output logic  dm_wr,
    output logic  integer_overflow
);

    ctrl_if   ctrl ();
    npc_sel_t npc_sel;
    logic     pc_wr;
    word_t    pc;

    ctrl_fsm i_fsm (
        .clk              (clk),
        .rst              (rst),
        .imem_data        (imem_data),
        .ctrl             (ctrl),
        .npc_sel          (npc_sel),
        .pc_wr            (pc_wr),
        .integer_overflow (integer_overflow)
    );

    pc_unit #(.RESET_PC(RESET_PC)) i_pc (
        .clk     (clk),
        .rst     (rst),
        .pc_wr   (pc_wr),
        .npc_sel (npc_sel),
        .ir_word (ctrl.ir_word),
        .pc      (pc)
    );

    datapath #(.NUM_REGS(NUM_REGS)) i_dp (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .dm_addr  (dm_addr),
        .dm_wdata (dm_wdata),
        .dm_rdata (dm_rdata)
    );

    assign imem_addr = pc;
    assign dm_wr     = ctrl.dm_wr;

endmodule

/* hdl/ctrl_fsm.sv */
`timescale 1ns/1ps

module ctrl_fsm import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  word_t    imem_data,
    ctrl_if.fsm      ctrl,
    output npc_sel_t npc_sel,
    output logic     pc_wr,
    output logic     integer_overflow
);

    state_t    state;
    state_t    state_nxt;
    word_t     ir_q;
    opcode_t   opcode;
    funct_t    funct;
    alu_op_t   funct_op;
    alu_op_t   imm_op;
    logic      known_funct;
    logic      is_rtype;
    logic      is_imm;
    logic      is_alu;
    logic      is_lw;
    logic      is_sw;
    logic      is_beq;
    logic      is_bne;
    logic      is_j;
    logic      is_known;
    logic      ovf_chk;
    logic      br_taken;

    assign opcode = opcode_t'(ir_q[31:26]);
    assign funct  = funct_t'(ir_q[5:0]);

    // instruction register loads at the end of fetch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ir_q <= '0;
        end else if (state == S_FETCH) begin
            ir_q <= imem_data;
        end
    end

    always_comb begin
        known_funct = 1'b1;
        case (funct)
            F_ADD, F_ADDU: funct_op = ALU_ADD;
            F_SUB, F_SUBU: funct_op = ALU_SUB;
            F_AND:         funct_op = ALU_AND;
            F_OR:          funct_op = ALU_OR;
            F_XOR:         funct_op = ALU_XOR;
            F_NOR:         funct_op = ALU_NOR;
            F_SLT:         funct_op = ALU_SLT;
            F_SLTU:        funct_op = ALU_SLTU;
            default: begin
                funct_op    = ALU_ADD;
                known_funct = 1'b0;
            end
        endcase
    end

    // lw and sw fall to the default add for address generation
    always_comb begin
        is_imm = 1'b1;
        case (opcode)
            OP_ADDI, OP_ADDIU: imm_op = ALU_ADD;
            OP_SLTI:           imm_op = ALU_SLT;
            OP_SLTIU:          imm_op = ALU_SLTU;
            OP_ANDI:           imm_op = ALU_AND;
            OP_ORI:            imm_op = ALU_OR;
            OP_XORI:           imm_op = ALU_XOR;
            default: begin
                imm_op = ALU_ADD;
                is_imm = 1'b0;
            end
        endcase
    end

    assign is_rtype = (opcode == OP_RTYPE) && known_funct;
    assign is_alu   = is_rtype || is_imm;
    assign is_lw    = (opcode == OP_LW);
    assign is_sw    = (opcode == OP_SW);
    assign is_beq   = (opcode == OP_BEQ);
    assign is_bne   = (opcode == OP_BNE);
    assign is_j     = (opcode == OP_J);
    assign is_known = is_alu || is_lw || is_sw || is_beq || is_bne || is_j;

    // only these three raise the overflow exception
    assign ovf_chk = (opcode == OP_ADDI) || (is_rtype && (funct == F_ADD || funct == F_SUB));

    always_comb begin
        case (state)
            S_FETCH: state_nxt = S_DECODE;
            S_DECODE: begin
                if (is_alu) begin
                    state_nxt = S_ALU_EXE;
                end else if (is_lw || is_sw) begin
                    state_nxt = S_MEM_ADDR;
                end else if (is_beq || is_bne) begin
                    state_nxt = S_BRANCH;
                end else if (is_j) begin
                    state_nxt = S_JUMP;
                end else begin
                    state_nxt = S_FETCH;
                end
            end
            S_ALU_EXE:  state_nxt = S_ALU_WR;
            S_MEM_ADDR: state_nxt = is_lw ? S_MEM_RD : S_MEM_WR;
            S_MEM_RD:   state_nxt = S_MEM_WB;
            default:    state_nxt = S_FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    // alu_zero holds rs == rt, sampled at the end of decode
    assign br_taken = (is_beq && ctrl.alu_zero) || (is_bne && !ctrl.alu_zero);

    assign npc_sel = (state == S_JUMP) ? NPC_JUMP :
                     (state == S_BRANCH && br_taken) ? NPC_BRANCH : NPC_SEQ;

    // last cycle of each instruction, unknown opcodes end in decode
    assign pc_wr = (state inside {S_ALU_WR, S_MEM_WB, S_MEM_WR, S_BRANCH, S_JUMP}) ||
                   (state == S_DECODE && !is_known);

    assign ctrl.ir_word     = ir_q;
    assign ctrl.rf_wr       = (state == S_ALU_WR) || (state == S_MEM_WB);
    assign ctrl.dm_wr       = (state == S_MEM_WR);
    assign ctrl.op2_sel     = is_rtype ? OP2_REG : OP2_IMM;
    assign ctrl.wr_addr_sel = is_rtype ? WA_RD : WA_RT;
    assign ctrl.wr_data_sel = (state == S_MEM_WB) ? WD_MEM : WD_ALU;
    assign ctrl.ext_mode    = (opcode inside {OP_ANDI, OP_ORI, OP_XORI}) ? EXT_ZERO : EXT_SIGN;
    assign ctrl.alu_op      = is_rtype ? funct_op : imm_op;

    assign integer_overflow = (state == S_ALU_WR) && ovf_chk && ctrl.alu_ovf;

    // a store comes only from sw, right after its address phase
    a_dm_wr_phase: assert property (@(posedge clk) disable iff (rst)
        ctrl.dm_wr |-> is_sw && ($past(state) == S_MEM_ADDR));

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {S_FETCH, S_DECODE, S_ALU_EXE, S_ALU_WR, S_MEM_ADDR,
                      S_MEM_RD, S_MEM_WB, S_MEM_WR, S_BRANCH, S_JUMP});

endmodule

/* hdl/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if import cpu_pkg::*; ();

    // from the state machine
    word_t        ir_word;
    logic         rf_wr;
    op2_sel_t     op2_sel;
    wr_addr_sel_t wr_addr_sel;
    wr_data_sel_t wr_data_sel;
    ext_mode_t    ext_mode;
    alu_op_t      alu_op;
    logic         dm_wr;

    // registered status from the datapath
    logic         alu_zero;
    logic         alu_ovf;

    modport fsm (
        output ir_word, rf_wr, op2_sel, wr_addr_sel, wr_data_sel, ext_mode, alu_op, dm_wr,
        input  alu_zero, alu_ovf
    );

    modport dp (
        input  ir_word, rf_wr, op2_sel, wr_addr_sel, wr_data_sel, ext_mode, alu_op, dm_wr,
        output alu_zero, alu_ovf
    );

endinterface

/* hdl/datapath.sv */
`timescale 1ns/1ps

module datapath import cpu_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic  clk,
    input  logic  rst,
    ctrl_if.dp    ctrl,
    output word_t dm_addr,
    output word_t dm_wdata,
    input  word_t dm_rdata
);

    word_t     imm_ext;
    word_t     rd_data1;
    word_t     rd_data2;
    word_t     a_q;
    word_t     b_q;
    word_t     op2;
    word_t     alu_result;
    logic      alu_overflow;
    word_t     result_q;
    word_t     mem_q;
    logic      zero_q;
    logic      ovf_q;
    reg_addr_t wr_addr;
    word_t     wr_data;

    assign imm_ext = (ctrl.ext_mode == EXT_ZERO) ? {16'b0, ctrl.ir_word[15:0]} :
                                                   {{16{ctrl.ir_word[15]}}, ctrl.ir_word[15:0]};

    assign op2     = (ctrl.op2_sel == OP2_IMM) ? imm_ext : b_q;
    assign wr_addr = (ctrl.wr_addr_sel == WA_RD) ? ctrl.ir_word[15:11] : ctrl.ir_word[20:16];
    assign wr_data = (ctrl.wr_data_sel == WD_MEM) ? mem_q : result_q;

    reg_file #(.NUM_REGS(NUM_REGS)) i_rf (
        .clk      (clk),
        .rst      (rst),
        .rd_addr1 (ctrl.ir_word[25:21]),
        .rd_addr2 (ctrl.ir_word[20:16]),
        .wr_addr  (wr_addr),
        .wr_en    (ctrl.rf_wr),
        .wr_data  (wr_data),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    alu_unit i_alu (
        .op1      (a_q),
        .op2      (op2),
        .alu_op   (ctrl.alu_op),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    // the ir is stable after fetch, so these settle by the end of decode
    // and hold for the rest of the instruction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_q      <= '0;
            b_q      <= '0;
            zero_q   <= 1'b0;
            result_q <= '0;
            ovf_q    <= 1'b0;
            mem_q    <= '0;
        end else begin
            a_q      <= rd_data1;
            b_q      <= rd_data2;
            // rs - rt == 0, ready in time for the branch phase
            zero_q   <= (rd_data1 == rd_data2);
            result_q <= alu_result;
            ovf_q    <= alu_overflow;
            mem_q    <= dm_rdata;
        end
    end

    assign ctrl.alu_zero = zero_q;
    assign ctrl.alu_ovf  = ovf_q;

    assign dm_addr  = result_q;
    assign dm_wdata = b_q;

endmodule

/* hdl/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit import cpu_pkg::*; #(
    parameter logic [ADDR_BITS-1:0] RESET_PC = '0
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     pc_wr,
    input  npc_sel_t npc_sel,
    input  word_t    ir_word,
    output word_t    pc
);

    word_t pc_plus4;
    word_t br_target;
    word_t jmp_target;
    word_t npc;

    assign pc_plus4   = pc + 32'd4;
    // offset is in words, relative to the delay-slot address
    assign br_target  = pc_plus4 + {{14{ir_word[15]}}, ir_word[15:0], 2'b00};
    assign jmp_target = {pc_plus4[31:28], ir_word[25:0], 2'b00};

    always_comb begin
        case (npc_sel)
            NPC_BRANCH: npc = br_target;
            NPC_JUMP:   npc = jmp_target;
            default:    npc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (pc_wr) begin
            pc <= npc;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc_wr |=> (pc[1:0] == 2'b00));

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rd_addr1,
    input  reg_addr_t rd_addr2,
    input  reg_addr_t wr_addr,
    input  logic      wr_en,
    input  word_t     wr_data,
    output word_t     rd_data1,
    output word_t     rd_data2
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // $zero is hardwired
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

endmodule

/* run.sh */
#!/usr/bin/env bash
# compile with Verilator, run from the project root, then scan sim.log
set -o pipefail
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f build.f \
        --top-module tb_top -Mdir obj_dir -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log \
    && ! grep -q "TESTS FAILED" sim.log \
    || { echo "simulation run failed"; exit 1; }

/* tests/cpu_testdata.txt */
# tag P: program word | D: data address, data word | S: store address, store data | V: count
# values in hex, text after the values on a line is ignored
P 20010005  # 000 addi $1, $0, 5
P 2002fffd  # 004 addi $2, $0, -3
P 00221820  # 008 add $3, $1, $2
P ac030100  # 00c sw $3, 0x100($0)
P 00221822  # 010 sub $3, $1, $2
P ac030104  # 014 sw $3, 0x104($0)
P 00221824  # 018 and $3, $1, $2
P ac030108  # 01c sw $3, 0x108($0)
P 00221825  # 020 or $3, $1, $2
P ac03010c  # 024 sw $3, 0x10c($0)
P 00221826  # 028 xor $3, $1, $2
P ac030110  # 02c sw $3, 0x110($0)
P 00221827  # 030 nor $3, $1, $2
P ac030114  # 034 sw $3, 0x114($0)
P 0041182a  # 038 slt $3, $2, $1
P ac030118  # 03c sw $3, 0x118($0)
P 0041182b  # 040 sltu $3, $2, $1
P ac03011c  # 044 sw $3, 0x11c($0)
P 3044ff00  # 048 andi $4, $2, 0xff00
P ac040120  # 04c sw $4, 0x120($0)
P 34048001  # 050 ori $4, $0, 0x8001
P ac040124  # 054 sw $4, 0x124($0)
P 20048001  # 058 addi $4, $0, 0x8001
P ac040128  # 05c sw $4, 0x128($0)
P 3844ffff  # 060 xori $4, $2, 0xffff
P ac04012c  # 064 sw $4, 0x12c($0)
P 2824ffff  # 068 slti $4, $1, -1
P ac040130  # 06c sw $4, 0x130($0)
P 2c44ffff  # 070 sltiu $4, $2, -1
P ac040134  # 074 sw $4, 0x134($0)
P 8c050200  # 078 lw $5, 0x200($0)
P 8c060204  # 07c lw $6, 0x204($0)
P 00a63821  # 080 addu $7, $5, $6
P ac070140  # 084 sw $7, 0x140($0)
P 8c080140  # 088 lw $8, 0x140($0)
P 01054026  # 08c xor $8, $8, $5
P ac080144  # 090 sw $8, 0x144($0)
P 20090200  # 094 addi $9, $0, 0x200
P 8d2a0004  # 098 lw $10, 4($9)
P ad2aff48  # 09c sw $10, -0xb8($9)
P 10210001  # 0a0 beq $1, $1, +1 (taken)
P ac010150  # 0a4 sw $1, 0x150($0) skipped
P 10220001  # 0a8 beq $1, $2, +1 (not taken)
P ac010154  # 0ac sw $1, 0x154($0)
P 14220001  # 0b0 bne $1, $2, +1 (taken)
P ac010158  # 0b4 sw $1, 0x158($0) skipped
P 14210001  # 0b8 bne $1, $1, +1 (not taken)
P ac02015c  # 0bc sw $2, 0x15c($0)
P 08000032  # 0c0 j 0x0c8
P ac010160  # 0c4 sw $1, 0x160($0) skipped
P 216b0001  # 0c8 addi $11, $11, 1
P 1561fffe  # 0cc bne $11, $1, -2 (loop five times)
P ac0b0164  # 0d0 sw $11, 0x164($0)
P 8c0c0208  # 0d4 lw $12, 0x208($0)
P 8c0d020c  # 0d8 lw $13, 0x20c($0)
P 01817020  # 0dc add $14, $12, $1 (overflow)
P ac0e0170  # 0e0 sw $14, 0x170($0)
P 01817821  # 0e4 addu $15, $12, $1
P ac0f0174  # 0e8 sw $15, 0x174($0)
P 218e0001  # 0ec addi $14, $12, 1 (overflow)
P ac0e0178  # 0f0 sw $14, 0x178($0)
P 258f0001  # 0f4 addiu $15, $12, 1
P ac0f017c  # 0f8 sw $15, 0x17c($0)
P 01a17022  # 0fc sub $14, $13, $1 (overflow)
P ac0e0180  # 100 sw $14, 0x180($0)
P 01a17823  # 104 subu $15, $13, $1
P ac0f0184  # 108 sw $15, 0x184($0)
P 018d8022  # 10c sub $16, $12, $13 (overflow)
P ac100188  # 110 sw $16, 0x188($0)
P 01828820  # 114 add $17, $12, $2
P ac11018c  # 118 sw $17, 0x18c($0)
P 08000047  # 11c j 0x11c (end of program)
D 00000200 12345678
D 00000204 0000ff00
D 00000208 7fffffff
D 0000020c 80000000
S 00000100 00000002  # add
S 00000104 00000008  # sub
S 00000108 00000005  # and
S 0000010c fffffffd  # or
S 00000110 fffffff8  # xor
S 00000114 00000002  # nor
S 00000118 00000001  # slt
S 0000011c 00000000  # sltu
S 00000120 0000ff00  # andi, zero extended
S 00000124 00008001  # ori, zero extended
S 00000128 ffff8001  # addi, sign extended
S 0000012c ffff0002  # xori, zero extended
S 00000130 00000000  # slti, sign extended
S 00000134 00000001  # sltiu, sign extended
S 00000140 12355578  # loaded words summed
S 00000144 00010300  # round trip through 0x140
S 00000148 0000ff00  # base plus negative offset
S 00000154 00000005  # beq not taken path
S 0000015c fffffffd  # bne not taken path
S 00000164 00000005  # loop counter
S 00000170 80000004  # add wraps
S 00000174 80000004  # addu
S 00000178 80000000  # addi wraps
S 0000017c 80000000  # addiu
S 00000180 7ffffffb  # sub wraps
S 00000184 7ffffffb  # subu
S 00000188 ffffffff  # sub of opposite signs wraps
S 0000018c 7ffffffc  # add without overflow
V 00000004

/* tests/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
    parameter int MAX_STORES = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] imem_addr,
    input  logic [31:0] dm_addr,
    input  logic [31:0] dm_wdata,
    input  logic        dm_wr,
    input  logic        integer_overflow,
    input  logic [31:0] exp_addr [MAX_STORES],
    input  logic [31:0] exp_data [MAX_STORES],
    input  int          n_stores,
    input  int          exp_ovf,
    input  logic        finish,
    output logic        all_seen,
    output int          mismatch_errs,
    output int          flow_errs
);

    int   store_idx    = 0;
    int   ovf_count    = 0;
    int   mismatch_cnt = 0;
    int   flow_cnt     = 0;
    logic left_reset   = 1'b0;
    logic final_done   = 1'b0;

    assign all_seen      = (store_idx >= n_stores);
    assign mismatch_errs = mismatch_cnt;
    assign flow_errs     = flow_cnt;

    // outputs settle after the rising edge, so look at them mid-cycle
    always @(negedge clk) begin
        // reset values, during reset and in the first cycle after it
        if (rst || !left_reset) begin
            if (dm_wr !== 1'b0) begin
                $display("dm_wr is not low during or just after reset at time %0t", $time);
                flow_cnt++;
            end
            if (integer_overflow !== 1'b0) begin
                $display("integer_overflow is not low during or just after reset at time %0t",
                         $time);
                flow_cnt++;
            end
            if (imem_addr !== 32'h0) begin
                $display("Mismatch time=%0t imem_addr: got %h expected %h",
                         $time, imem_addr, 32'h0);
                mismatch_cnt++;
            end
        end
        if (!rst) begin
            left_reset = 1'b1;
        end

        if (!rst && dm_wr === 1'b1) begin
            if (store_idx >= n_stores) begin
                $display("extra store at time %0t to address %h with data %h",
                         $time, dm_addr, dm_wdata);
                flow_cnt++;
            end else begin
                if (dm_addr !== exp_addr[store_idx]) begin
                    $display("Mismatch time=%0t dm_addr: got %h expected %h",
                             $time, dm_addr, exp_addr[store_idx]);
                    mismatch_cnt++;
                end
                if (dm_wdata !== exp_data[store_idx]) begin
                    $display("Mismatch time=%0t dm_wdata: got %h expected %h",
                             $time, dm_wdata, exp_data[store_idx]);
                    mismatch_cnt++;
                end
                store_idx++;
            end
        end

        if (!rst && integer_overflow === 1'b1) begin
            ovf_count++;
        end

        if (finish && !final_done) begin
            final_done = 1'b1;
            if (store_idx < n_stores) begin
                $display("%0d of %0d expected stores never happened",
                         n_stores - store_idx, n_stores);
                flow_cnt++;
            end
            if (ovf_count != exp_ovf) begin
                $display("Mismatch time=%0t integer_overflow cycle count: got %0d expected %0d",
                         $time, ovf_count, exp_ovf);
                mismatch_cnt++;
            end
        end
    end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int    MEM_WORDS  = 256;
    localparam int    MAX_STORES = 64;
    localparam string DATA_FILE  = "tests/cpu_testdata.txt";

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dm_addr;
    logic [31:0] dm_wdata;
    logic [31:0] dm_rdata;
    logic        dm_wr;
    logic        integer_overflow;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] exp_addr [MAX_STORES];
    logic [31:0] exp_data [MAX_STORES];

    int   n_prog   = 0;
    int   n_stores = 0;
    int   exp_ovf  = 0;
    int   limit    = 0;
    int   run_errs = 0;
    int   mismatch_errs;
    int   flow_errs;
    logic all_stores_seen;
    logic finish_chk;

    initial begin
        forever #2 clk = ~clk;
    end

    // both memories answer in the same cycle
    assign imem_data = imem[imem_addr[9:2]];
    assign dm_rdata  = dmem[dm_addr[9:2]];

    always @(posedge clk) begin
        if (dm_wr) begin
            dmem[dm_addr[9:2]] <= dm_wdata;
        end
    end

    cpu_top #(.RESET_PC(32'h0), .NUM_REGS(32)) i_dut (
        .clk              (clk),
        .rst              (rst),
        .imem_addr        (imem_addr),
        .imem_data        (imem_data),
        .dm_addr          (dm_addr),
        .dm_wdata         (dm_wdata),
        .dm_rdata         (dm_rdata),
        .dm_wr            (dm_wr),
        .integer_overflow (integer_overflow)
    );

    tb_checker #(.MAX_STORES(MAX_STORES)) i_chk (
        .clk              (clk),
        .rst              (rst),
        .imem_addr        (imem_addr),
        .dm_addr          (dm_addr),
        .dm_wdata         (dm_wdata),
        .dm_wr            (dm_wr),
        .integer_overflow (integer_overflow),
        .exp_addr         (exp_addr),
        .exp_data         (exp_data),
        .n_stores         (n_stores),
        .exp_ovf          (exp_ovf),
        .finish           (finish_chk),
        .all_seen         (all_stores_seen),
        .mismatch_errs    (mismatch_errs),
        .flow_errs        (flow_errs)
    );

    // tagged lines: P program word, D data word, S expected store, V overflow count
    task automatic read_data_file(output logic ok);
        int          fd;
        int          cnt;
        string       line;
        byte         tag;
        logic [31:0] val_a;
        logic [31:0] val_b;
        ok = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = 32'h0;
            // filler carries the word address so unloaded reads are recognisable
            dmem[i] = 32'hd0000000 | (i << 2);
        end
        fd = $fopen(DATA_FILE, "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                cnt  = $fgets(line, fd);
                if (cnt > 1) begin
                    tag = line.getc(0);
                    val_a = 32'h0;
                    val_b = 32'h0;
                    cnt = $sscanf(line.substr(1, line.len() - 1), "%h %h", val_a, val_b);
                    case (tag)
                        "P": begin
                            imem[n_prog] = val_a;
                            n_prog++;
                        end
                        "D": dmem[val_a[9:2]] = val_b;
                        "S": begin
                            exp_addr[n_stores] = val_a;
                            exp_data[n_stores] = val_b;
                            n_stores++;
                        end
                        "V": exp_ovf = val_a;
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic finish_run();
        int total;
        total = mismatch_errs + flow_errs + run_errs;
        $display("error counts: %0d mismatches, %0d store or reset errors, %0d run errors",
                 mismatch_errs, flow_errs, run_errs);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    initial begin : main
        logic load_ok;
        rst        = 1'b1;
        finish_chk = 1'b0;
        read_data_file(load_ok);
        if (load_ok) begin
            // every instruction at most 5 cycles, loops allowed for
            limit = n_prog * 5 * 4 + 100;
            repeat (3) @(posedge clk);
            #1 rst = 1'b0;
            wait (all_stores_seen);
            repeat (20) @(posedge clk);
            #1 finish_chk = 1'b1;
            @(negedge clk);
            #1;
        end else begin
            $display("could not open the test data file %s", DATA_FILE);
            run_errs++;
        end
        finish_run();
    end

    initial begin : watchdog
        int cycle;
        cycle = 0;
        wait (limit > 0);
        while (cycle < limit) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout: the program did not finish within %0d cycles", limit);
        run_errs++;
        finish_run();
    end

endmodule
